//--- bench/mp_props.sv
`timescale 1ns/1ps

module mp_props (
    input logic clock,
    input logic reset_n,
    input logic start,
    input logic busy,
    input logic done
);

    // failed assertions so far, summed into the final count by the testbench
    int fail_count = 0;

    // sequencer comes out of reset idle
    reset_idle: assert property (@(posedge clock) !reset_n |=> (!busy && !done))
        else begin
            fail_count = fail_count + 1;
            $error("busy or done is high right after reset");
        end

    done_single_cycle: assert property (@(posedge clock) disable iff (!reset_n)
        done |=> !done)
        else begin
            fail_count = fail_count + 1;
            $error("done stayed high for more than one cycle");
        end

    // busy drops in the same cycle as the done pulse
    busy_falls_with_done: assert property (@(posedge clock) disable iff (!reset_n)
        $fell(busy) |-> done)
        else begin
            fail_count = fail_count + 1;
            $error("busy fell without a done pulse");
        end

    done_ends_busy: assert property (@(posedge clock) disable iff (!reset_n)
        done |-> (!busy && $past(busy)))
        else begin
            fail_count = fail_count + 1;
            $error("done pulsed while busy was not ending");
        end

    busy_needs_start: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(busy) |-> $past(start))
        else begin
            fail_count = fail_count + 1;
            $error("busy rose without a start in the cycle before");
        end

endmodule

bind mp_top mp_props mp_props_inst (
    .clock(clock),
    .reset_n(reset_n),
    .start(start),
    .busy(busy),
    .done(done)
);

//--- bench/mp_tb.sv
`timescale 1ns/1ps
`include "mp_config.svh"

module mp_tb
    import mp_fixed_pkg::*;
    import mp_stage_pkg::*;
();

    localparam int one_q16 = 1 << `MP_Q;
    localparam int done_timeout = 1000;
    // iter_start to the next iter_start: sweep, winner, residual update, restart
    localparam int iter_cycles = `MP_N * (`MP_M + 1) + `MP_M + 6;

    logic       clock = 1'b0;
    logic       reset_n;
    logic       start;
    sample_wr_t y_wr;
    logic       dict_wr_en;
    dict_addr_t dict_wr_addr;
    sample_t    dict_wr_data;
    atom_idx_t  x_rd_addr;
    sample_t    x_rd_data;
    logic       busy;
    logic       done;

    integer  seed;
    int      errors;
    int      errors_at_test;
    int      tests_run;
    int      tests_failed;
    int      total_errors;
    sample_t y_vec [`MP_M];
    sample_t exp_x [`MP_N];

    mp_top mp_top_inst (
        .clock(clock), .reset_n(reset_n), .start(start), .y_wr(y_wr),
        .dict_wr_en(dict_wr_en), .dict_wr_addr(dict_wr_addr), .dict_wr_data(dict_wr_data),
        .x_rd_addr(x_rd_addr), .x_rd_data(x_rd_data), .busy(busy), .done(done)
    );

    always #50 clock = ~clock;

    function automatic void check_value(sample_t got, sample_t expected, string what);
        assert (got == expected) else begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            errors++;
        end
    endfunction

    // unit vectors for the first M atoms, the rest stay zero
    task automatic load_dictionary();
        for (int a = 0; a < `MP_N; a++) begin
            for (int e = 0; e < `MP_M; e++) begin
                @(posedge clock);
                dict_wr_en   <= 1'b1;
                dict_wr_addr <= dict_addr_t'(a * `MP_M + e);
                dict_wr_data <= (a == e) ? sample_t'(one_q16) : '0;
            end
        end
        @(posedge clock);
        dict_wr_en <= 1'b0;
    endtask

    task automatic load_signal();
        for (int i = 0; i < `MP_M; i++) begin
            @(posedge clock);
            y_wr.en   <= 1'b1;
            y_wr.addr <= elem_idx_t'(i);
            y_wr.data <= y_vec[i];
        end
        @(posedge clock);
        y_wr.en <= 1'b0;
    endtask

    // magnitudes stay below 16.0
    task automatic randomize_signal();
        integer r;
        for (int i = 0; i < `MP_M; i++) begin
            r = $random(seed);
            y_vec[i] = sample_t'(r % 1048576);
        end
    endtask

    // each pass takes the largest remaining magnitude, lower index on a tie,
    // and that sample leaves the residual
    task automatic build_model();
        sample_t resid [`MP_M];
        sample_t best_mag;
        sample_t mag;
        int      best;
        for (int n = 0; n < `MP_N; n++) begin
            exp_x[n] = '0;
        end
        for (int i = 0; i < `MP_M; i++) begin
            resid[i] = y_vec[i];
        end
        for (int k = 0; k < `MP_K; k++) begin
            best_mag = '0;
            best     = 0;
            for (int i = 0; i < `MP_M; i++) begin
                mag = (resid[i] < 0) ? -resid[i] : resid[i];
                if (mag > best_mag) begin
                    best_mag = mag;
                    best     = i;
                end
            end
            exp_x[best] = exp_x[best] + resid[best];
            resid[best] = '0;
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!done && cycles < done_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            $display("timeout: done did not pulse within %0d cycles, time %0t",
                     done_timeout, $time);
            $display("** FAIL **");
            $finish;
        end
    endtask

    // optionally pulse start again in the second iteration,
    // after x already holds the first winner
    task automatic run_engine(input bit extra_start);
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        if (extra_start) begin
            repeat (iter_cycles + 10) @(negedge clock);
            check_value(sample_t'(busy), 1, "busy at the extra start");
            @(posedge clock);
            start <= 1'b1;
            @(posedge clock);
            start <= 1'b0;
        end
        wait_for_done();
    endtask

    task automatic check_solution();
        for (int n = 0; n < `MP_N; n++) begin
            @(posedge clock);
            x_rd_addr <= atom_idx_t'(n);
            @(posedge clock);
            @(negedge clock);
            check_value(x_rd_data, exp_x[n], $sformatf("x[%0d]", n));
        end
    endtask

    // a new address every cycle, data for each one a cycle later
    task automatic check_streamed_reads();
        @(posedge clock);
        x_rd_addr <= '0;
        for (int n = 1; n <= `MP_N; n++) begin
            @(posedge clock);
            if (n < `MP_N) begin
                x_rd_addr <= atom_idx_t'(n);
            end
            @(negedge clock);
            check_value(x_rd_data, exp_x[n-1], $sformatf("streamed x[%0d]", n - 1));
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_test) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_at_test);
            tests_failed++;
        end
        errors_at_test = errors;
    endtask

    initial begin
        seed           = 32'hf390;
        errors         = 0;
        errors_at_test = 0;
        tests_run      = 0;
        tests_failed   = 0;
        reset_n        = 1'b0;
        start          = 1'b0;
        y_wr           = '0;
        dict_wr_en     = 1'b0;
        dict_wr_addr   = '0;
        dict_wr_data   = '0;
        x_rd_addr      = '0;
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;

        @(negedge clock);
        check_value(sample_t'(busy), 0, "busy after reset");
        check_value(sample_t'(done), 0, "done after reset");
        load_dictionary();
        finish_test("reset state");

        randomize_signal();
        build_model();
        load_signal();
        run_engine(1'b0);
        check_solution();
        finish_test("random signal");

        // largest magnitude is -7.5 at index 1
        y_vec[0] = sample_t'(3 * one_q16);
        y_vec[1] = sample_t'(-15 * (one_q16 / 2));
        y_vec[2] = sample_t'(2 * one_q16);
        y_vec[3] = sample_t'(one_q16 / 4);
        build_model();
        load_signal();
        run_engine(1'b0);
        check_solution();
        finish_test("negative maximum");

        // three samples of magnitude 5.0, only indexes 1 and 2 win
        y_vec[0] = sample_t'(one_q16);
        y_vec[1] = sample_t'(-5 * one_q16);
        y_vec[2] = sample_t'(5 * one_q16);
        y_vec[3] = sample_t'(5 * one_q16);
        build_model();
        load_signal();
        run_engine(1'b0);
        check_solution();
        finish_test("equal magnitudes");

        // winners move to indexes 3 and 0, old entries must read zero
        y_vec[0] = sample_t'(6 * one_q16);
        y_vec[1] = sample_t'(one_q16 / 2);
        y_vec[2] = sample_t'(-(one_q16 / 2));
        y_vec[3] = sample_t'(-9 * one_q16);
        build_model();
        load_signal();
        run_engine(1'b0);
        check_solution();
        finish_test("second run without reset");

        randomize_signal();
        build_model();
        load_signal();
        run_engine(1'b1);
        check_streamed_reads();
        finish_test("start while busy and read timing");

        total_errors = errors + mp_top_inst.mp_props_inst.fail_count;
        $display("tests run %0d, tests failed %0d, failed checks %0d, failed assertions %0d",
                 tests_run, tests_failed, errors, mp_top_inst.mp_props_inst.fail_count);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hdl/mp_argmax.sv
`timescale 1ns/1ps

module mp_argmax
    import mp_fixed_pkg::*;
    import mp_stage_pkg::*;
(
    input  logic     clock,
    input  logic     reset_n,
    input  product_t product,
    output winner_t  winner
);

    sample_t   best_mag;
    sample_t   best_val;
    atom_idx_t best_loc;
    sample_t   cur_mag;
    logic      take;

    // magnitudes compare unsigned, so the most negative value still ranks highest
    // strict compare keeps the lower index on a tie
    always_comb begin
        cur_mag = (product.value < 0) ? -product.value : product.value;
        take    = $unsigned(cur_mag) > $unsigned(best_mag);
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            winner.valid <= 1'b0;
            best_mag     <= '0;
            best_val     <= '0;
            best_loc     <= '0;
        end else begin
            winner.valid <= 1'b0;
            if (product.valid) begin
                if (product.last) begin
                    winner.valid    <= 1'b1;
                    winner.location <= take ? product.atom : best_loc;
                    winner.value    <= take ? product.value : best_val;
                    // start clean for the next sweep
                    best_mag        <= '0;
                    best_val        <= '0;
                    best_loc        <= '0;
                end else if (take) begin
                    best_mag <= cur_mag;
                    best_val <= product.value;
                    best_loc <= product.atom;
                end
            end
        end
    end

endmodule

//--- hdl/mp_config.svh
`ifndef MP_CONFIG_SVH
`define MP_CONFIG_SVH

// signal length in samples
`define MP_M 4

// number of atoms in the dictionary
`define MP_N 8

// matching pursuit iterations per run
`define MP_K 2

// fraction bits of the fixed-point format
`define MP_Q 16

// width of one sample word
`define MP_SAMPLE_W 32

`endif

//--- hdl/mp_correlator.sv
`timescale 1ns/1ps
`include "mp_config.svh"

module mp_correlator
    import mp_fixed_pkg::*;
    import mp_stage_pkg::*;
(
    input  logic       clock,
    input  logic       reset_n,
    input  logic       iter_start,
    output sample_rd_t res_rd,
    output sample_rd_t dict_rd,
    input  sample_t    res_data,
    input  sample_t    dict_data,
    output product_t   product
);

    corr_state_t state;
    atom_idx_t   atom;
    elem_idx_t   elem;
    acc_t        acc;
    acc_t        term;
    logic        data_ok;

    // bank data is one cycle behind the request
    assign term = acc_t'(res_data) * acc_t'(dict_data);

    always_comb begin
        res_rd.valid  = (state == CORR_READ);
        res_rd.addr   = dict_addr_t'(elem);
        dict_rd.valid = (state == CORR_READ);
        dict_rd.addr  = dict_addr(atom, elem);
    end

    // per atom: M read cycles, then one drain cycle for the last pair
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state         <= CORR_IDLE;
            atom          <= '0;
            elem          <= '0;
            acc           <= '0;
            data_ok       <= 1'b0;
            product.valid <= 1'b0;
            product.last  <= 1'b0;
        end else begin
            data_ok       <= (state == CORR_READ);
            product.valid <= 1'b0;
            product.last  <= 1'b0;
            case (state)
                CORR_IDLE: begin
                    if (iter_start) begin
                        state <= CORR_READ;
                        atom  <= '0;
                        elem  <= '0;
                        acc   <= '0;
                    end
                end
                CORR_READ: begin
                    if (data_ok) begin
                        acc <= acc + term;
                    end
                    if (elem == elem_idx_t'(`MP_M - 1)) begin
                        state <= CORR_DRAIN;
                        elem  <= '0;
                    end else begin
                        elem <= elem + elem_idx_t'(1);
                    end
                end
                CORR_DRAIN: begin
                    product.valid <= 1'b1;
                    product.atom  <= atom;
                    product.value <= fx_scale(acc + term);
                    product.last  <= (atom == atom_idx_t'(`MP_N - 1));
                    acc           <= '0;
                    if (atom == atom_idx_t'(`MP_N - 1)) begin
                        state <= CORR_IDLE;
                    end else begin
                        atom  <= atom + atom_idx_t'(1);
                        state <= CORR_READ;
                    end
                end
                default: begin
                    state <= CORR_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/mp_dict_bank.sv
`timescale 1ns/1ps
`include "mp_config.svh"

module mp_dict_bank
    import mp_fixed_pkg::*;
    import mp_stage_pkg::*;
(
    input  logic       clock,
    input  logic       busy,
    input  logic       host_wr_en,
    input  dict_addr_t host_wr_addr,
    input  sample_t    host_wr_data,
    input  sample_rd_t corr_rd,
    input  sample_rd_t upd_rd,
    output sample_t    rd_data
);

    sample_t    mem [`MP_N * `MP_M];
    sample_rd_t rd;

    // correlator and updater never read at the same time
    assign rd = corr_rd.valid ? corr_rd : upd_rd;

    always_ff @(posedge clock) begin
        if (host_wr_en && !busy) begin
            mem[host_wr_addr] <= host_wr_data;
        end
        if (rd.valid) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

//--- hdl/mp_fixed_pkg.sv
`include "mp_config.svh"

package mp_fixed_pkg;

    // signed fixed point, MP_Q fraction bits
    typedef logic signed [`MP_SAMPLE_W-1:0] sample_t;
    // full-precision products and sums
    typedef logic signed [2*`MP_SAMPLE_W-1:0] acc_t;

    typedef logic [$clog2(`MP_M)-1:0] elem_idx_t;
    typedef logic [$clog2(`MP_N)-1:0] atom_idx_t;
    typedef logic [$clog2(`MP_N*`MP_M)-1:0] dict_addr_t;
    typedef logic [$clog2(`MP_K+1)-1:0] iter_idx_t;

    // atom n, element i is stored at n*M+i
    function automatic dict_addr_t dict_addr(atom_idx_t atom, elem_idx_t elem);
        return dict_addr_t'(atom) * dict_addr_t'(`MP_M) + dict_addr_t'(elem);
    endfunction

    // drop the extra fraction bits of a product back to one sample
    function automatic sample_t fx_scale(acc_t value);
        return sample_t'(value >>> `MP_Q);
    endfunction

endpackage

//--- hdl/mp_residual_bank.sv
`timescale 1ns/1ps
`include "mp_config.svh"

module mp_residual_bank
    import mp_fixed_pkg::*;
    import mp_stage_pkg::*;
(
    input  logic       clock,
    input  logic       reset_n,
    input  logic       busy,
    input  sample_wr_t host_wr,
    input  sample_wr_t upd_wr,
    input  sample_rd_t corr_rd,
    input  sample_rd_t upd_rd,
    output sample_t    rd_data
);

    sample_t    mem [`MP_M];
    sample_wr_t wr;
    sample_rd_t rd;

    // host loads y while idle, the updater owns the bank during a run
    always_comb begin
        wr = busy ? upd_wr : host_wr;
        rd = corr_rd.valid ? corr_rd : upd_rd;
    end

    always_ff @(posedge clock) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        if (!reset_n) begin
            rd_data <= '0;
        end else if (rd.valid) begin
            rd_data <= mem[elem_idx_t'(rd.addr)];
        end
    end

endmodule

//--- hdl/mp_sequencer.sv
`timescale 1ns/1ps
`include "mp_config.svh"

module mp_sequencer
    import mp_fixed_pkg::*;
    import mp_stage_pkg::*;
(
    input  logic clock,
    input  logic reset_n,
    input  logic start,
    input  logic iter_done,
    output logic iter_start,
    output logic busy,
    output logic done
);

    seq_state_t state;
    iter_idx_t  iter_cnt;

    // busy follows the state so it rises the cycle after start
    assign busy = (state == SEQ_RUN);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= SEQ_IDLE;
            iter_cnt   <= '0;
            iter_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            iter_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state      <= SEQ_RUN;
                        iter_cnt   <= '0;
                        iter_start <= 1'b1;
                    end
                end
                SEQ_RUN: begin
                    if (iter_done) begin
                        if (iter_cnt == iter_idx_t'(`MP_K - 1)) begin
                            // last iteration finished, busy drops with done
                            state <= SEQ_IDLE;
                            done  <= 1'b1;
                        end else begin
                            iter_cnt   <= iter_cnt + iter_idx_t'(1);
                            iter_start <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/mp_stage_pkg.sv
package mp_stage_pkg;

    import mp_fixed_pkg::*;

    // one inner product per atom, last marks the end of the sweep
    typedef struct packed {
        logic      valid;
        atom_idx_t atom;
        sample_t   value;
        logic      last;
    } product_t;

    // signed product of the winning atom
    typedef struct packed {
        logic      valid;
        atom_idx_t location;
        sample_t   value;
    } winner_t;

    typedef struct packed {
        logic      en;
        elem_idx_t addr;
        sample_t   data;
    } sample_wr_t;

    // address is wide enough for either bank
    typedef struct packed {
        logic       valid;
        dict_addr_t addr;
    } sample_rd_t;

    typedef enum logic {SEQ_IDLE, SEQ_RUN} seq_state_t;
    typedef enum logic [1:0] {CORR_IDLE, CORR_READ, CORR_DRAIN} corr_state_t;
    typedef enum logic [1:0] {UPD_IDLE, UPD_READ, UPD_FLUSH, UPD_FINISH} upd_state_t;

endpackage

//--- hdl/mp_top.sv
`timescale 1ns/1ps

module mp_top
    import mp_fixed_pkg::*;
    import mp_stage_pkg::*;
(
    input  logic       clock,
    input  logic       reset_n,
    input  logic       start,
    input  sample_wr_t y_wr,
    input  logic       dict_wr_en,
    input  dict_addr_t dict_wr_addr,
    input  sample_t    dict_wr_data,
    input  atom_idx_t  x_rd_addr,
    output sample_t    x_rd_data,
    output logic       busy,
    output logic       done
);

    logic       iter_start;
    logic       iter_done;
    sample_t    res_data;
    sample_t    dict_data;
    sample_rd_t corr_res_rd;
    sample_rd_t corr_dict_rd;
    sample_rd_t upd_res_rd;
    sample_rd_t upd_dict_rd;
    sample_wr_t upd_res_wr;
    product_t   product;
    winner_t    winner;

    mp_sequencer mp_sequencer_inst (
        .clock(clock), .reset_n(reset_n), .start(start), .iter_done(iter_done),
        .iter_start(iter_start), .busy(busy), .done(done)
    );

    mp_residual_bank mp_residual_bank_inst (
        .clock(clock), .reset_n(reset_n), .busy(busy),
        .host_wr(y_wr), .upd_wr(upd_res_wr),
        .corr_rd(corr_res_rd), .upd_rd(upd_res_rd), .rd_data(res_data)
    );

    mp_dict_bank mp_dict_bank_inst (
        .clock(clock), .busy(busy),
        .host_wr_en(dict_wr_en), .host_wr_addr(dict_wr_addr), .host_wr_data(dict_wr_data),
        .corr_rd(corr_dict_rd), .upd_rd(upd_dict_rd), .rd_data(dict_data)
    );

    mp_correlator mp_correlator_inst (
        .clock(clock), .reset_n(reset_n), .iter_start(iter_start),
        .res_rd(corr_res_rd), .dict_rd(corr_dict_rd),
        .res_data(res_data), .dict_data(dict_data), .product(product)
    );

    mp_argmax mp_argmax_inst (
        .clock(clock), .reset_n(reset_n), .product(product), .winner(winner)
    );

    mp_updater mp_updater_inst (
        .clock(clock), .reset_n(reset_n), .start(start), .busy(busy), .winner(winner),
        .res_rd(upd_res_rd), .dict_rd(upd_dict_rd),
        .res_data(res_data), .dict_data(dict_data), .res_wr(upd_res_wr),
        .iter_done(iter_done), .x_rd_addr(x_rd_addr), .x_rd_data(x_rd_data)
    );

endmodule

//--- hdl/mp_updater.sv
`timescale 1ns/1ps
`include "mp_config.svh"

module mp_updater
    import mp_fixed_pkg::*;
    import mp_stage_pkg::*;
(
    input  logic       clock,
    input  logic       reset_n,
    input  logic       start,
    input  logic       busy,
    input  winner_t    winner,
    output sample_rd_t res_rd,
    output sample_rd_t dict_rd,
    input  sample_t    res_data,
    input  sample_t    dict_data,
    output sample_wr_t res_wr,
    output logic       iter_done,
    input  atom_idx_t  x_rd_addr,
    output sample_t    x_rd_data
);

    sample_t    x_mem [`MP_N];
    upd_state_t state;
    elem_idx_t  elem;
    elem_idx_t  elem_d;
    logic       data_ok;
    atom_idx_t  loc;
    sample_t    coef;
    sample_t    scaled;

    // winning product times the atom element
    assign scaled = fx_scale(acc_t'(coef) * acc_t'(dict_data));

    always_comb begin
        res_rd.valid  = (state == UPD_READ);
        res_rd.addr   = dict_addr_t'(elem);
        dict_rd.valid = (state == UPD_READ);
        dict_rd.addr  = dict_addr(loc, elem);
    end

    // solution vector, cleared on an accepted start
    always_ff @(posedge clock) begin
        if (start && !busy) begin
            for (int i = 0; i < `MP_N; i++) begin
                x_mem[i] <= '0;
            end
        end else if (winner.valid) begin
            x_mem[winner.location] <= x_mem[winner.location] + winner.value;
        end
        x_rd_data <= x_mem[x_rd_addr];
    end

    // read r[i] and atom[i], write back r[i] - coef*atom[i] two cycles later
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state     <= UPD_IDLE;
            elem      <= '0;
            data_ok   <= 1'b0;
            res_wr.en <= 1'b0;
            iter_done <= 1'b0;
        end else begin
            iter_done   <= 1'b0;
            data_ok     <= (state == UPD_READ);
            elem_d      <= elem;
            res_wr.en   <= data_ok;
            res_wr.addr <= elem_d;
            res_wr.data <= res_data - scaled;
            case (state)
                UPD_IDLE: begin
                    if (winner.valid) begin
                        loc   <= winner.location;
                        coef  <= winner.value;
                        elem  <= '0;
                        state <= UPD_READ;
                    end
                end
                UPD_READ: begin
                    if (elem == elem_idx_t'(`MP_M - 1)) begin
                        state <= UPD_FLUSH;
                    end else begin
                        elem <= elem + elem_idx_t'(1);
                    end
                end
                // last pair arrives here
                UPD_FLUSH: state <= UPD_FINISH;
                // last write is on the bank port now
                UPD_FINISH: begin
                    iter_done <= 1'b1;
                    state     <= UPD_IDLE;
                end
                default: state <= UPD_IDLE;
            endcase
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the matching pursuit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mp_tb -f sim.f -o mp_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/mp_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '** FAIL **' sim.log; then
    exit 1
fi
exit 0

//--- sim.f
+incdir+hdl
hdl/mp_fixed_pkg.sv
hdl/mp_stage_pkg.sv
hdl/mp_residual_bank.sv
hdl/mp_dict_bank.sv
hdl/mp_sequencer.sv
hdl/mp_correlator.sv
hdl/mp_argmax.sv
hdl/mp_updater.sv
hdl/mp_top.sv
bench/mp_props.sv
bench/mp_tb.sv
